/* branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
  input  fetch_pkg::predec_t dec,
  input  logic [31:0]        rdata1,
  input  logic [31:0]        rdata2,
  input  logic [31:0]        pc,
  output logic               taken,
  output logic [31:0]        target
);

  import rv_isa_pkg::*;

  logic        eq;
  logic        lt;
  logic        ltu;
  logic        cond;
  logic [31:0] reg_sum;

  assign eq  = (rdata1 == rdata2);
  assign lt  = ($signed(rdata1) < $signed(rdata2));
  assign ltu = (rdata1 < rdata2);

  always_comb begin
    case (dec.bcu_op)
      f3_beq:  cond = eq;
      f3_bne:  cond = !eq;
      f3_blt:  cond = lt;
      f3_bge:  cond = !lt;
      f3_bltu: cond = ltu;
      f3_bgeu: cond = !ltu;
      default: cond = 1'b0; // funct3 010 and 011 are not branches
    endcase
  end

  assign reg_sum = rdata1 + dec.imm;

  // jalr drops the low bit of its sum, the rest are pc relative
  assign target = dec.jalr ? {reg_sum[31:1], 1'b0} : pc + dec.imm;

  assign taken = dec.jal || dec.jalr || (dec.branch && cond);

endmodule

/* build.f */
rv_isa_pkg.sv
fetch_pkg.sv
fetch_ctrl.sv
pc_counter.sv
predecoder.sv
register_file.sv
branch_unit.sv
fetch_top.sv
fetch_tb.sv

/* fetch_ctrl.sv */
`timescale 1ns/100ps

module fetch_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic run,
  input  logic imem_ready,
  input  logic rsp_valid,
  input  logic out_ready,
  output logic req_valid,
  output logic out_valid,
  output logic capture,
  output logic step
);

  typedef enum logic [1:0] {
    s_idle,
    s_req,
    s_wait,
    s_hold
  } state_e;

  state_e state;
  state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      s_idle: begin
        if (run) begin
          state_nxt = s_req;
        end
      end
      s_req: begin
        if (imem_ready) begin
          state_nxt = s_wait; // request accepted by the memory
        end
      end
      s_wait: begin
        if (rsp_valid) begin
          state_nxt = s_hold;
        end
      end
      s_hold: begin
        if (out_ready) begin
          state_nxt = run ? s_req : s_idle;
        end
      end
      default: begin
        state_nxt = s_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= s_idle;
    end else begin
      state <= state_nxt;
    end
  end

  assign req_valid = (state == s_req);
  assign out_valid = (state == s_hold);

  // the response word is only taken while a request is outstanding
  assign capture = (state == s_wait) && rsp_valid;

  // next pc is known only once the packet leaves, since the branch decides it
  assign step = (state == s_hold) && out_ready;

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

  localparam logic [31:0] reset_pc = 32'h0000_0000; // first fetch address
  localparam logic [31:0] pc_step  = 32'd4;         // no compressed words, so always one word

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } imem_rsp_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        wren;
    logic        rden1;
    logic        rden2;
    logic        lui;
    logic        auipc;
    logic        jal;
    logic        jalr;
    logic        branch;
    logic        load;
    logic        store;
    logic        illegal;
    logic [2:0]  bcu_op;
  } predec_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  addr;
    logic [31:0] data;
  } wb_t;

  // packet handed to the next stage
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    predec_t     dec;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        taken;
    logic [31:0] target;
  } decode_out_t;

endpackage

/* fetch_tb.sv */
`timescale 1ns/100ps

module fetch_tb;

  import rv_isa_pkg::*;
  import fetch_pkg::*;

  localparam int num_instr   = 50;
  localparam int cycle_limit = 40 * num_instr + 200;

  logic          clk;
  logic          rst;
  logic          run;
  logic          imem_ready;
  imem_req_t     imem_req;
  imem_rsp_t     imem_rsp;
  wb_t           wb;
  logic          out_valid;
  logic          out_ready;
  decode_out_t   out_data;

  logic [31:0] program_mem [int]; // keyed by word address
  logic [31:0] shadow_regs [32];
  logic [31:0] exp_pc;
  int          accepted;
  logic        mem_busy;

  fetch_top DUT (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .imem_ready (imem_ready),
    .imem_req   (imem_req),
    .imem_rsp   (imem_rsp),
    .wb         (wb),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic end_in_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    end_in_failure();
  endtask

  task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, got);
      end_in_failure();
    end
  endtask

  task automatic check_decode(input string name, input decode_out_t exp, input decode_out_t got);
    if (got !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, got);
      end_in_failure();
    end
  endtask

  function automatic logic [31:0] r_type_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type_word(logic [6:0] opc, logic [4:0] rd, logic [2:0] f3,
                                              logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                              logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                              logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type_word(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type_word(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (program_mem.exists(int'(addr >> 2))) begin
      return program_mem[int'(addr >> 2)];
    end
    return nop_word;
  endfunction

  // expected packet from the RV32I encoding rules, plus the pc that must follow it
  function automatic decode_out_t ref_decode(input logic [31:0] pc, input logic [31:0] w,
                                             output logic [31:0] next_pc);
    decode_out_t r;
    predec_t     d;
    logic        cond;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'h000};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    d = '0;
    case (w[6:0])
      7'b0110111: {d.rd, d.imm, d.wren, d.lui} = {w[11:7], imm_u, 2'b11};
      7'b0010111: {d.rd, d.imm, d.wren, d.auipc} = {w[11:7], imm_u, 2'b11};
      7'b1101111: {d.rd, d.imm, d.wren, d.jal} = {w[11:7], imm_j, 2'b11};
      7'b1100111: begin
        {d.rd, d.rs1, d.imm} = {w[11:7], w[19:15], imm_i};
        {d.wren, d.rden1, d.jalr} = 3'b111;
      end
      7'b1100011: begin
        {d.rs1, d.rs2, d.imm, d.bcu_op} = {w[19:15], w[24:20], imm_b, w[14:12]};
        {d.rden1, d.rden2, d.branch} = 3'b111;
      end
      7'b0000011: begin
        {d.rd, d.rs1, d.imm} = {w[11:7], w[19:15], imm_i};
        {d.wren, d.rden1, d.load} = 3'b111;
      end
      7'b0100011: begin
        {d.rs1, d.rs2, d.imm} = {w[19:15], w[24:20], imm_s};
        {d.rden1, d.rden2, d.store} = 3'b111;
      end
      7'b0010011: {d.rd, d.rs1, d.imm, d.wren, d.rden1} = {w[11:7], w[19:15], imm_i, 2'b11};
      7'b0110011: begin
        {d.rd, d.rs1, d.rs2} = {w[11:7], w[19:15], w[24:20]};
        {d.wren, d.rden1, d.rden2} = 3'b111;
      end
      default: d.illegal = 1'b1;
    endcase
    r.pc     = pc;
    r.instr  = w;
    r.dec    = d;
    r.rdata1 = shadow_regs[d.rs1];
    r.rdata2 = shadow_regs[d.rs2];
    case (w[14:12])
      3'b000:  cond = (r.rdata1 == r.rdata2);
      3'b001:  cond = (r.rdata1 != r.rdata2);
      3'b100:  cond = ($signed(r.rdata1) < $signed(r.rdata2));
      3'b101:  cond = ($signed(r.rdata1) >= $signed(r.rdata2));
      3'b110:  cond = (r.rdata1 < r.rdata2);
      3'b111:  cond = (r.rdata1 >= r.rdata2);
      default: cond = 1'b0;
    endcase
    r.taken  = d.jal || d.jalr || (d.branch && cond);
    r.target = d.jalr ? ((r.rdata1 + d.imm) & 32'hffff_fffe) : pc + d.imm;
    next_pc  = r.taken ? r.target : pc + 32'd4;
    return r;
  endfunction

  function automatic logic [31:0] preload_value(input int i);
    case (i)
      1, 2:    return 32'd5;
      3:       return 32'hffff_fffd;
      4:       return 32'd7;
      5:       return 32'h8000_0000;
      6:       return 32'h7fff_ffff;
      7:       return 32'h0000_0059; // odd base, jalr must clear bit 0
      default: return $urandom;
    endcase
  endfunction

  task automatic load_program();
    program_mem[0]  = i_type_word(opc_op_imm, 5'd8, 3'b000, 5'd1, 12'd12);
    program_mem[1]  = r_type_word(7'h20, 5'd2, 5'd0, 3'b000, 5'd9); // reads x0
    program_mem[2]  = i_type_word(opc_load, 5'd10, 3'b010, 5'd3, -12'd8);
    program_mem[3]  = s_type_word(3'b010, 5'd5, 5'd4, -12'd20);
    program_mem[4]  = u_type_word(opc_lui, 5'd11, 20'habcde);
    program_mem[5]  = u_type_word(opc_auipc, 5'd12, 20'h12345);
    program_mem[6]  = b_type_word(f3_beq, 5'd1, 5'd2, 13'd8);
    program_mem[8]  = b_type_word(f3_bne, 5'd1, 5'd2, 13'd8);
    program_mem[9]  = b_type_word(f3_blt, 5'd3, 5'd1, 13'd8);
    program_mem[11] = b_type_word(f3_bge, 5'd3, 5'd1, 13'd8);
    program_mem[12] = b_type_word(f3_bltu, 5'd3, 5'd1, 13'd8);
    program_mem[13] = b_type_word(f3_bgeu, 5'd3, 5'd1, 13'd8);
    program_mem[15] = j_type_word(5'd13, 21'd16);
    program_mem[19] = i_type_word(opc_jalr, 5'd14, 3'b000, 5'd7, 12'd4);
    program_mem[23] = 32'h1234_507f; // opcode 1111111 is not RV32I
    program_mem[24] = b_type_word(f3_beq, 5'd5, 5'd6, 13'd8);
    program_mem[25] = b_type_word(f3_bne, 5'd5, 5'd6, 13'd8);
    program_mem[27] = b_type_word(f3_blt, 5'd6, 5'd5, 13'd8);
    program_mem[28] = b_type_word(f3_bge, 5'd6, 5'd5, 13'd8);
    program_mem[30] = b_type_word(f3_bltu, 5'd6, 5'd5, 13'd8);
    program_mem[32] = b_type_word(f3_bgeu, 5'd6, 5'd5, 13'd8);
    program_mem[33] = j_type_word(5'd0, -21'd132); // back to the start
  endtask

  initial begin : imem_model
    logic        xfer;
    logic [31:0] req_addr;
    logic [31:0] addr;
    int          lat;
    imem_ready = 1'b0;
    imem_rsp   = '0;
    mem_busy   = 1'b0;
    addr       = '0;
    lat        = 0;
    forever begin
      @(negedge clk);
      xfer     = imem_req.valid && imem_ready;
      req_addr = imem_req.addr;
      if (xfer) begin
        if (mem_busy) begin
          report_error("new fetch request while a response was still outstanding");
        end
        check_pc("fetch address", exp_pc, req_addr);
      end
      @(posedge clk);
      #1;
      imem_rsp.valid = 1'b0;
      if (mem_busy) begin
        if (lat == 0) begin
          imem_rsp.valid = 1'b1;
          imem_rsp.rdata = fetch_word(addr);
          mem_busy       = 1'b0;
        end else begin
          lat--;
        end
      end
      if (xfer) begin
        mem_busy = 1'b1;
        addr     = req_addr;
        lat      = $urandom % 4;
      end
      imem_ready = ($urandom % 4) != 0;
    end
  end

  initial begin : packet_checker
    decode_out_t exp_pkt;
    decode_out_t held;
    logic [31:0] next_pc;
    logic        waiting;
    out_ready = 1'b0;
    waiting   = 1'b0;
    held      = '0;
    forever begin
      @(negedge clk);
      if (out_valid) begin
        if (waiting) begin
          check_decode("packet held under back-pressure", held, out_data);
        end
        if (out_ready) begin
          exp_pkt = ref_decode(exp_pc, fetch_word(exp_pc), next_pc);
          check_pc($sformatf("pc of packet %0d", accepted), exp_pc, out_data.pc);
          check_decode($sformatf("packet %0d", accepted), exp_pkt, out_data);
          exp_pc   = next_pc;
          accepted = accepted + 1;
          waiting  = 1'b0;
        end else begin
          held    = out_data;
          waiting = 1'b1;
        end
      end else if (waiting) begin
        report_error("out_valid dropped before the packet was accepted");
      end
      @(posedge clk);
      #1;
      out_ready = ($urandom % 3) != 0;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= cycle_limit) begin
        report_error($sformatf("timeout, no finish within %0d cycles", cycle_limit));
      end
    end
  end

  initial begin : main
    logic [31:0] v;
    void'($urandom(32'h7094_210b));
    rst      = 1'b0;
    run      = 1'b0;
    wb       = '0;
    exp_pc   = reset_pc;
    accepted = 0;
    for (int i = 0; i < 32; i++) begin
      shadow_regs[i] = '0;
    end
    load_program();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;
    for (int i = 0; i < 32; i++) begin
      @(posedge clk);
      #1;
      v        = (i == 0) ? 32'hdead_beef : preload_value(i); // x0 must stay zero
      wb.valid = 1'b1;
      wb.addr  = 5'(i);
      wb.data  = v;
      if (i != 0) begin
        shadow_regs[i] = v;
      end
      @(negedge clk);
      if (imem_req.valid || out_valid) begin
        report_error("fetch started before run was raised");
      end
      check_pc("first fetch address", reset_pc, imem_req.addr);
    end
    @(posedge clk);
    #1;
    wb  = '0;
    run = 1'b1;
    wait (accepted >= num_instr);
    @(posedge clk);
    #1;
    run = 1'b0;
    @(negedge clk);
    while (imem_req.valid || out_valid || imem_rsp.valid || mem_busy) @(negedge clk);
    repeat (10) begin
      @(negedge clk);
      if (imem_req.valid || out_valid) begin
        report_error("fetch went on after run was lowered");
      end
    end
    if (accepted == num_instr + 1) begin // the fetch started before run fell still completes
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      report_error("wrong number of packets accepted after run was lowered");
    end
  end

endmodule

/* fetch_top.sv */
`timescale 1ns/100ps

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  run,
  input  logic                  imem_ready,
  output fetch_pkg::imem_req_t  imem_req,
  input  fetch_pkg::imem_rsp_t  imem_rsp,
  input  fetch_pkg::wb_t        wb,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fetch_pkg::decode_out_t out_data
);

  import rv_isa_pkg::*;
  import fetch_pkg::*;

  instr_t      instr_q;
  predec_t     dec;
  logic [31:0] pc;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] target;
  logic        taken;
  logic        req_valid;
  logic        capture;
  logic        step;

  fetch_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .imem_ready (imem_ready),
    .rsp_valid  (imem_rsp.valid),
    .out_ready  (out_ready),
    .req_valid  (req_valid),
    .out_valid  (out_valid),
    .capture    (capture),
    .step       (step)
  );

  pc_counter u_pc (
    .clk    (clk),
    .rst    (rst),
    .step   (step),
    .taken  (taken),
    .target (target),
    .pc     (pc)
  );

  // holds a nop until the first response so the decode path sees a legal word
  always_ff @(posedge clk) begin
    if (!rst) begin
      instr_q <= nop_word;
    end else if (capture) begin
      instr_q <= imem_rsp.rdata;
    end
  end

  predecoder u_predec (
    .instr (instr_q),
    .dec   (dec)
  );

  register_file u_regs (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (dec.rs1),
    .raddr2 (dec.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wb     (wb)
  );

  branch_unit u_bcu (
    .dec    (dec),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .pc     (pc),
    .taken  (taken),
    .target (target)
  );

  assign imem_req.valid = req_valid;
  assign imem_req.addr  = pc; // pc stays put until the packet is taken

  assign out_data.pc     = pc;
  assign out_data.instr  = instr_q;
  assign out_data.dec    = dec;
  assign out_data.rdata1 = rdata1;
  assign out_data.rdata2 = rdata2;
  assign out_data.taken  = taken;
  assign out_data.target = target;

endmodule

/* pc_counter.sv */
`timescale 1ns/100ps

module pc_counter (
  input  logic        clk,
  input  logic        rst,
  input  logic        step,
  input  logic        taken,
  input  logic [31:0] target,
  output logic [31:0] pc
);

  import fetch_pkg::*;

  logic [31:0] pc_next;

  assign pc_next = taken ? target : pc + pc_step; // redirect wins over the sequential step

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc <= reset_pc;
    end else if (step) begin
      pc <= pc_next;
    end
  end

endmodule

/* predecoder.sv */
`timescale 1ns/100ps

module predecoder (
  input  rv_isa_pkg::instr_t instr,
  output fetch_pkg::predec_t dec
);

  import rv_isa_pkg::*;

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
  assign imm_s = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
  assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                  instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {instr.u_fmt.imm_31_12, 12'h000};
  assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                  instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    dec = '0; // register fields a format does not use read as x0
    case (instr.r_fmt.opcode)
      opc_lui: begin
        dec.rd   = instr.u_fmt.rd;
        dec.imm  = imm_u;
        dec.wren = 1'b1;
        dec.lui  = 1'b1;
      end
      opc_auipc: begin
        dec.rd    = instr.u_fmt.rd;
        dec.imm   = imm_u;
        dec.wren  = 1'b1;
        dec.auipc = 1'b1;
      end
      opc_jal: begin
        dec.rd   = instr.j_fmt.rd;
        dec.imm  = imm_j;
        dec.wren = 1'b1;
        dec.jal  = 1'b1;
      end
      opc_jalr: begin
        dec.rd    = instr.i_fmt.rd;
        dec.rs1   = instr.i_fmt.rs1;
        dec.imm   = imm_i;
        dec.wren  = 1'b1;
        dec.rden1 = 1'b1;
        dec.jalr  = 1'b1;
      end
      opc_branch: begin
        dec.rs1    = instr.b_fmt.rs1;
        dec.rs2    = instr.b_fmt.rs2;
        dec.imm    = imm_b;
        dec.rden1  = 1'b1;
        dec.rden2  = 1'b1;
        dec.branch = 1'b1;
        dec.bcu_op = instr.b_fmt.funct3; // picks the compare in the branch unit
      end
      opc_load: begin
        dec.rd    = instr.i_fmt.rd;
        dec.rs1   = instr.i_fmt.rs1;
        dec.imm   = imm_i;
        dec.wren  = 1'b1;
        dec.rden1 = 1'b1;
        dec.load  = 1'b1;
      end
      opc_store: begin
        dec.rs1   = instr.s_fmt.rs1;
        dec.rs2   = instr.s_fmt.rs2;
        dec.imm   = imm_s;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.store = 1'b1;
      end
      opc_op_imm: begin
        dec.rd    = instr.i_fmt.rd;
        dec.rs1   = instr.i_fmt.rs1;
        dec.imm   = imm_i;
        dec.wren  = 1'b1;
        dec.rden1 = 1'b1;
      end
      opc_op: begin
        dec.rd    = instr.r_fmt.rd;
        dec.rs1   = instr.r_fmt.rs1;
        dec.rs2   = instr.r_fmt.rs2;
        dec.wren  = 1'b1;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
      end
      default: begin
        dec.illegal = 1'b1; // flagged only, nothing is written
      end
    endcase
  end

endmodule

/* register_file.sv */
`timescale 1ns/100ps

module register_file (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       raddr1,
  input  logic [4:0]       raddr2,
  output logic [31:0]      rdata1,
  output logic [31:0]      rdata2,
  input  fetch_pkg::wb_t   wb
);

  logic [31:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && (wb.addr != 5'd0)) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // no bypass, a write shows up on the cycle after it
  assign rdata1 = (raddr1 == 5'd0) ? 32'h0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? 32'h0 : regs[raddr2];

endmodule

/* run.sh */
#!/bin/sh
# builds the fetch front end with Verilator and runs the testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module fetch_tb -f build.f -o fetch_sim
./obj_dir/fetch_sim

/* rv_isa_pkg.sv */
package rv_isa_pkg;

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_e;

  // compare kinds of the conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [31:0] nop_word = 32'h0000_0013; // addi x0,x0,0

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one instruction word, seen through each encoding format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage
